// File: all.f
+incdir+testbench
logic/switch_pkg.sv
logic/ingress_queue.sv
logic/flow_table.sv
logic/action_resolver.sv
logic/switch_stage.sv
testbench/switch_stage_tb.sv

// File: testbench/switch_vectors.svh
`ifndef SWITCH_VECTORS_SVH
`define SWITCH_VECTORS_SVH

// one row per packet, expected columns follow the resolver rules by hand
typedef struct packed {
    logic [1:0] phase;
    flow_key_t  dst_key;
    flow_key_t  src_key;
    logic       drop;
    port_mask_t ports;
} vector_t;

localparam int NUM_PROG = 9;
localparam int NUM_ROWS = 21;
localparam int NUM_PHASES = 3;

// en, table, index, valid, key, data
localparam ctrl_wr_t PROG_LIST [NUM_PROG] = '{
    '{1'b1, DST_TABLE, 3'd0, 1'b1, 16'h0A01, 8'h01},
    '{1'b1, DST_TABLE, 3'd1, 1'b1, 16'h0A02, 8'h06},
    '{1'b1, DST_TABLE, 3'd2, 1'b1, 16'h0A03, 8'h08},
    '{1'b1, DST_TABLE, 3'd3, 1'b1, 16'h0A04, 8'h0C},
    '{1'b1, DST_TABLE, 3'd4, 1'b0, 16'h0A05, 8'h02},
    '{1'b1, DST_TABLE, 3'd5, 1'b1, 16'h0A03, 8'h03},
    '{1'b1, DST_TABLE, 3'd6, 1'b1, 16'h0A06, 8'hF2},
    '{1'b1, ACL_TABLE, 3'd0, 1'b1, 16'h5001, 8'h01},
    '{1'b1, ACL_TABLE, 3'd1, 1'b1, 16'h5002, 8'h00}
};

// invalidates dst entry 3 between phase 0 and phase 1
localparam ctrl_wr_t CLEAR_WR = '{1'b1, DST_TABLE, 3'd3, 1'b0, 16'h0A04, 8'h0C};

// phase 0 basic lookups, 1 after the clear, 2 with egress credits held back
localparam vector_t VECTORS [NUM_ROWS] = '{
    '{2'd0, 16'h0A01, 16'h1234, 1'b0, 4'h1},
    '{2'd0, 16'h0A02, 16'h1235, 1'b0, 4'h6},
    '{2'd0, 16'h0A03, 16'h5002, 1'b0, 4'h8},
    '{2'd0, 16'h0A04, 16'h1236, 1'b0, 4'hC},
    '{2'd0, 16'h0A05, 16'h1237, 1'b0, 4'hF},
    '{2'd0, 16'h0BEE, 16'h1238, 1'b0, 4'hF},
    '{2'd0, 16'h0A01, 16'h5001, 1'b1, 4'h0},
    '{2'd0, 16'h0A06, 16'h1239, 1'b0, 4'h2},
    '{2'd0, 16'h0A06, 16'h5002, 1'b0, 4'h2},
    '{2'd0, 16'h0A02, 16'h5001, 1'b1, 4'h0},
    '{2'd1, 16'h0A04, 16'h1240, 1'b0, 4'hF},
    '{2'd1, 16'h0A01, 16'h1241, 1'b0, 4'h1},
    '{2'd1, 16'h0A04, 16'h5001, 1'b1, 4'h0},
    '{2'd2, 16'h0A01, 16'h2001, 1'b0, 4'h1},
    '{2'd2, 16'h0A02, 16'h2002, 1'b0, 4'h6},
    '{2'd2, 16'h0A03, 16'h2003, 1'b0, 4'h8},
    '{2'd2, 16'h0A04, 16'h2004, 1'b0, 4'hF},
    '{2'd2, 16'h0A05, 16'h2005, 1'b0, 4'hF},
    '{2'd2, 16'h0A06, 16'h2006, 1'b0, 4'h2},
    '{2'd2, 16'h0BEE, 16'h2007, 1'b0, 4'hF},
    '{2'd2, 16'h0A02, 16'h2008, 1'b0, 4'h6}
};

`endif

// File: testbench/switch_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module switch_stage_tb
    import switch_pkg::*;
;

    `include "switch_vectors.svh"

    localparam int SEED = 32'h20f2d6c2;
    localparam int RESET_CYCLES = 16;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40 + RESET_CYCLES;

    logic        clk;
    logic        rst_n_i;
    logic        pkt_valid_i;
    hdr_t        pkt_hdr_i;
    logic        in_credit_o;
    ctrl_wr_t    ctrl_wr_i;
    logic        pkt_valid_o;
    egress_pkt_t pkt_o;
    logic        out_credit_i = 1'b0;
    drop_cnt_t   drop_cnt_o;

    egress_pkt_t exp_q [$];
    drop_cnt_t   exp_drops = '0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          push_count = 0;
    int          credit_pulses = 0;
    int          rx_count = 0;
    int          owed = 0;
    logic        withhold = 1'b0;

    switch_stage UUT (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .pkt_valid_i(pkt_valid_i),
        .pkt_hdr_i(pkt_hdr_i),
        .in_credit_o(in_credit_o),
        .ctrl_wr_i(ctrl_wr_i),
        .pkt_valid_o(pkt_valid_o),
        .pkt_o(pkt_o),
        .out_credit_i(out_credit_i),
        .drop_cnt_o(drop_cnt_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_hdr(input string name, input hdr_t got, input hdr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_port(input string name, input port_mask_t got, input port_mask_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_drops(input string name, input drop_cnt_t got, input drop_cnt_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apply_write(input ctrl_wr_t wr);
        ctrl_wr_i = wr;
        @(negedge clk);
        ctrl_wr_i = '0;
    endtask

    // caller sits on a falling edge, returns on one
    task automatic push_row(input vector_t row);
        hdr_t        hdr;
        egress_pkt_t exp;
        int          gap;
        hdr = {row.dst_key, row.src_key, $urandom(), $urandom(), $urandom()};
        gap = $urandom_range(3, 0);
        repeat (gap) @(negedge clk);
        // sender credits
        while (IN_DEPTH + credit_pulses - push_count <= 0) begin
            @(negedge clk);
        end
        pkt_valid_i = 1'b1;
        pkt_hdr_i = hdr;
        push_count++;
        if (row.drop) begin
            exp_drops++;
        end else begin
            exp.hdr = hdr;
            exp.ports = row.ports;
            exp_q.push_back(exp);
        end
        @(negedge clk);
        pkt_valid_i = 1'b0;
    endtask

    // everything popped, last result through the two-stage pipe
    task automatic drain();
        while (exp_q.size() != 0 || push_count != credit_pulses) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        check_drops("drop_cnt_o", drop_cnt_o, exp_drops);
    endtask

    // output monitor and downstream credit model
    always @(negedge clk) begin
        egress_pkt_t exp;
        if (in_credit_o) begin
            credit_pulses++;
        end
        if (pkt_valid_o) begin
            rx_count++;
            owed++;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("packet left the switch when none was expected");
            end else begin
                exp = exp_q.pop_front();
                check_hdr("pkt_o.hdr", pkt_o.hdr, exp.hdr);
                check_port("pkt_o.ports", pkt_o.ports, exp.ports);
            end
        end
        if (!withhold && owed > 0) begin
            out_credit_i = 1'b1;
            owed--;
        end else begin
            out_credit_i = 1'b0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int rx_base;
        int pulse_base;
        int push_base;
        rst_n_i = 1'b0;
        pkt_valid_i = 1'b0;
        pkt_hdr_i = '0;
        ctrl_wr_i = '0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        // idle outputs after reset
        repeat (4) begin
            @(negedge clk);
            check_flag("pkt_valid_o", pkt_valid_o, 1'b0);
            check_flag("in_credit_o", in_credit_o, 1'b0);
            check_drops("drop_cnt_o", drop_cnt_o, '0);
        end

        for (int i = 0; i < NUM_PROG; i++) begin
            apply_write(PROG_LIST[i]);
        end

        for (int p = 0; p < NUM_PHASES; p++) begin
            if (p == 1) begin
                apply_write(CLEAR_WR);
            end
            rx_base = rx_count;
            pulse_base = credit_pulses;
            push_base = push_count;
            withhold = (p == 2);
            fork
                for (int r = 0; r < NUM_ROWS; r++) begin
                    if (VECTORS[r].phase == p) begin
                        push_row(VECTORS[r]);
                    end
                end
                begin
                    if (p == 2) begin
                        wait (rx_count - rx_base >= OUT_CREDITS);
                        repeat (20) @(negedge clk);
                        if (rx_count - rx_base != OUT_CREDITS) begin
                            other_errors++;
                            $display("%0d packets left while egress credits were held back",
                                     rx_count - rx_base);
                        end
                        if (credit_pulses - pulse_base > IN_DEPTH + OUT_CREDITS) begin
                            other_errors++;
                            $display("too many input credits returned under back-pressure");
                        end
                        if (push_count - push_base != IN_DEPTH + OUT_CREDITS) begin
                            other_errors++;
                            $display("queue did not fill up while egress was stalled");
                        end
                        withhold = 1'b0;
                    end
                end
            join
            drain();
        end

        $display("summary: %0d value errors, %0d other errors, %0d packets out, %0d dropped",
                 value_errors, other_errors, rx_count, exp_drops);
        if (value_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/switch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module switch_stage
    import switch_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n_i,
    // sender
    input  wire         pkt_valid_i,
    input  hdr_t        pkt_hdr_i,
    output logic        in_credit_o,
    // controller
    input  ctrl_wr_t    ctrl_wr_i,
    // downstream
    output logic        pkt_valid_o,
    output egress_pkt_t pkt_o,
    input  wire         out_credit_i,
    output drop_cnt_t   drop_cnt_o
);

    logic        head_valid;
    hdr_t        head_hdr;
    logic        pop;
    lookup_res_t dst_res;
    lookup_res_t acl_res;

    ingress_queue in_queue (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .push_i(pkt_valid_i),
        .push_hdr_i(pkt_hdr_i),
        .pop_i(pop),
        .head_valid_o(head_valid),
        .head_hdr_o(head_hdr),
        .in_credit_o(in_credit_o)
    );

    // destination key to port mask
    flow_table #(
        .TABLE_ID(DST_TABLE),
        .KEY_OFF(DST_KEY_OFF)
    ) dst_table (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .ctrl_wr_i(ctrl_wr_i),
        .lookup_i(pop),
        .lookup_hdr_i(head_hdr),
        .result_o(dst_res)
    );

    // source key to permit or deny
    flow_table #(
        .TABLE_ID(ACL_TABLE),
        .KEY_OFF(SRC_KEY_OFF)
    ) acl_table (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .ctrl_wr_i(ctrl_wr_i),
        .lookup_i(pop),
        .lookup_hdr_i(head_hdr),
        .result_o(acl_res)
    );

    action_resolver resolver (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .head_valid_i(head_valid),
        .head_hdr_i(head_hdr),
        .pop_o(pop),
        .dst_res_i(dst_res),
        .acl_res_i(acl_res),
        .out_credit_i(out_credit_i),
        .pkt_valid_o(pkt_valid_o),
        .pkt_o(pkt_o),
        .drop_cnt_o(drop_cnt_o)
    );

endmodule

`default_nettype wire

// File: logic/action_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module action_resolver
    import switch_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n_i,
    // ingress queue head
    input  wire         head_valid_i,
    input  hdr_t        head_hdr_i,
    output logic        pop_o,
    // lookup results, one cycle after pop
    input  lookup_res_t dst_res_i,
    input  lookup_res_t acl_res_i,
    // egress side
    input  wire         out_credit_i,
    output logic        pkt_valid_o,
    output egress_pkt_t pkt_o,
    output drop_cnt_t   drop_cnt_o
);

    credit_cnt_t credit_cnt;
    credit_cnt_t credit_next;

    // header waiting for its lookups
    logic        stg_valid;
    hdr_t        stg_hdr;

    logic        deny;
    logic        stg_drop;
    logic        stg_fwd;
    port_mask_t  fwd_mask;

    // issue only with a reserved egress credit
    assign pop_o = head_valid_i && (credit_cnt != '0);

    assign deny = acl_res_i.hit && acl_res_i.data[0];
    assign stg_drop = stg_valid && deny;
    assign stg_fwd = stg_valid && !deny;
    assign fwd_mask = dst_res_i.hit ? dst_res_i.data[NUM_PORTS - 1:0] : FLOOD_MASK;

    always_comb begin
        credit_next = credit_cnt;
        if (pop_o) begin
            credit_next = credit_next - 1'b1;
        end
        if (out_credit_i) begin
            credit_next = credit_next + 1'b1;
        end
        // dropped packet hands its credit back
        if (stg_drop) begin
            credit_next = credit_next + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_cnt <= credit_cnt_t'(OUT_CREDITS);
        end else begin
            credit_cnt <= credit_next;
        end
    end

    // align the header with the table results
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stg_valid <= 1'b0;
        end else begin
            stg_valid <= pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            stg_hdr <= head_hdr_i;
        end
    end

    // output stage
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pkt_valid_o <= 1'b0;
            drop_cnt_o <= '0;
        end else begin
            pkt_valid_o <= stg_fwd;
            if (stg_drop) begin
                drop_cnt_o <= drop_cnt_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stg_fwd) begin
            pkt_o.hdr <= stg_hdr;
            pkt_o.ports <= fwd_mask;
        end
    end

    // downstream never returns more than it was given
    assert property (@(posedge clk) disable iff (!rst_n_i)
        credit_cnt <= credit_cnt_t'(OUT_CREDITS))
        else $error("egress credit count %0d above limit", credit_cnt);

    // empty pool stays empty until something comes back
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (credit_cnt == '0 && !out_credit_i && !stg_drop) |=> (credit_cnt == '0))
        else $error("egress credit count wrapped below zero");

endmodule

`default_nettype wire

// File: logic/flow_table.sv
`timescale 1ns/1ps
`default_nettype none

module flow_table
    import switch_pkg::*;
#(
    parameter table_sel_t TABLE_ID = DST_TABLE,
    parameter int         KEY_OFF = 0
) (
    input  wire         clk,
    input  wire         rst_n_i,
    // controller writes
    input  ctrl_wr_t    ctrl_wr_i,
    // lookup request
    input  wire         lookup_i,
    input  hdr_t        lookup_hdr_i,
    output lookup_res_t result_o
);

    // top bit of the key inside the header
    localparam int KEY_MSB = HDR_BITS - 1 - 8 * KEY_OFF;

    logic [TABLE_ENTRIES - 1:0] ent_valid;
    flow_key_t                  ent_key [TABLE_ENTRIES];
    entry_data_t                ent_data [TABLE_ENTRIES];

    logic                       wr_hit;
    flow_key_t                  lookup_key;
    logic [TABLE_ENTRIES - 1:0] match_vec;
    logic                       match_hit;
    entry_data_t                match_data;

    assign wr_hit = ctrl_wr_i.en && (ctrl_wr_i.sel == TABLE_ID);
    assign lookup_key = lookup_hdr_i[KEY_MSB -: KEY_BITS];

    // entry valid bits
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ent_valid <= '0;
        end else if (wr_hit) begin
            ent_valid[ctrl_wr_i.idx] <= ctrl_wr_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            ent_key[ctrl_wr_i.idx] <= ctrl_wr_i.key;
            ent_data[ctrl_wr_i.idx] <= ctrl_wr_i.data;
        end
    end

    // compare all entries at once
    always_comb begin
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            match_vec[i] = ent_valid[i] && (ent_key[i] == lookup_key);
        end
    end

    // lowest index wins, so scan downwards
    always_comb begin
        match_hit = 1'b0;
        match_data = '0;
        for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                match_hit = 1'b1;
                match_data = ent_data[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o <= '0;
        end else if (lookup_i) begin
            result_o.hit <= match_hit;
            result_o.data <= match_data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_hit |-> (int'(ctrl_wr_i.idx) < TABLE_ENTRIES))
        else $error("table %0d write index %0d out of range", TABLE_ID, ctrl_wr_i.idx);

endmodule

`default_nettype wire

// File: logic/ingress_queue.sv
`timescale 1ns/1ps
`default_nettype none

module ingress_queue
    import switch_pkg::*;
(
    input  wire  clk,
    input  wire  rst_n_i,
    // sender side
    input  wire  push_i,
    input  hdr_t push_hdr_i,
    // resolver side
    input  wire  pop_i,
    output logic head_valid_o,
    output hdr_t head_hdr_o,
    // one credit back per pop
    output logic in_credit_o
);

    hdr_t        mem [IN_DEPTH];
    in_ptr_t     wr_ptr;
    in_ptr_t     rd_ptr;
    credit_cnt_t count;
    logic        full;
    logic        do_pop;

    function automatic in_ptr_t ptr_inc(input in_ptr_t ptr);
        if (ptr == in_ptr_t'(IN_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == credit_cnt_t'(IN_DEPTH));
    assign head_valid_o = (count != '0);
    assign head_hdr_o = mem[rd_ptr];
    assign do_pop = pop_i && head_valid_o;

    // header storage
    always_ff @(posedge clk) begin
        if (push_i && !full) begin
            mem[wr_ptr] <= push_hdr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push_i && !full) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_i && !full, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // credit goes back the cycle after the pop
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_credit_o <= 1'b0;
        end else begin
            in_credit_o <= do_pop;
        end
    end

    // sender must hold a credit for every push
    assert property (@(posedge clk) disable iff (!rst_n_i) !(push_i && full))
        else $error("ingress push while queue full, sender overran its credits");

endmodule

`default_nettype wire

// File: logic/switch_pkg.sv
`default_nettype none

package switch_pkg;

    // packet header, byte 0 sits in the top bits
    localparam int HDR_BYTES = 16;
    localparam int HDR_BITS = HDR_BYTES * 8;
    typedef logic [HDR_BITS - 1:0] hdr_t;

    localparam int NUM_PORTS = 4;
    typedef logic [NUM_PORTS - 1:0] port_mask_t;
    localparam port_mask_t FLOOD_MASK = '1;

    // fixed key positions
    localparam int KEY_BITS = 16;
    typedef logic [KEY_BITS - 1:0] flow_key_t;
    localparam int DST_KEY_OFF = 0;
    localparam int SRC_KEY_OFF = 2;

    localparam int DATA_BITS = 8;
    typedef logic [DATA_BITS - 1:0] entry_data_t;

    localparam int TABLE_ENTRIES = 8;
    localparam int IDX_BITS = $clog2(TABLE_ENTRIES);
    typedef logic [IDX_BITS - 1:0] entry_idx_t;

    typedef logic [0:0] table_sel_t;
    localparam table_sel_t DST_TABLE = 1'b0;
    localparam table_sel_t ACL_TABLE = 1'b1;

    // controller write, one entry per cycle
    typedef struct packed {
        logic        en;
        table_sel_t  sel;
        entry_idx_t  idx;
        logic        valid;
        flow_key_t   key;
        entry_data_t data;
    } ctrl_wr_t;

    typedef struct packed {
        logic        hit;
        entry_data_t data;
    } lookup_res_t;

    typedef struct packed {
        hdr_t       hdr;
        port_mask_t ports;
    } egress_pkt_t;

    // credits and counters
    localparam int IN_DEPTH = 4;
    localparam int IN_PTR_BITS = $clog2(IN_DEPTH);
    typedef logic [IN_PTR_BITS - 1:0] in_ptr_t;
    localparam int OUT_CREDITS = 2;
    typedef logic [2:0] credit_cnt_t;
    typedef logic [15:0] drop_cnt_t;

endpackage

`default_nettype wire
